// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_ctl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS: pass message found in $(LOG)" || \
		(echo "FAIL: pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/lsu_pkg.sv
// Shared widths, packet, stage payload and error report types for the LSU control pipeline
package lsu_pkg;

   // ********************
   // Widths
   // ********************

   localparam int XLEN        = 32;  // Data and address width
   localparam int NUM_THREADS = 2;
   localparam int TID_W       = 1;   // Wide enough for NUM_THREADS

   // ********************
   // Access-fault causes
   // ********************

   localparam logic [2:0] MSCAUSE_NONE         = 3'h0;
   localparam logic [2:0] MSCAUSE_REGION_CROSS = 3'h1;  // Start and end in different regions
   localparam logic [2:0] MSCAUSE_PIC_SIZE     = 3'h2;  // PIC only takes words
   localparam logic [2:0] MSCAUSE_UNMAPPED     = 3'h3;  // Atomic outside DCCM and PIC

   // Control packet of one core access
   typedef struct packed {
      logic             valid;
      logic [TID_W-1:0] tid;
      logic             load;
      logic             store;
      logic             by;
      logic             half;
      logic             word;
      logic             unsign;
      logic             lr;      // Also sets atomic
      logic             sc;      // Also sets atomic
      logic             atomic;
   } lsu_pkt_t;

   // One-hot memory region
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   // Payload carried through DC1 to DC3
   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] end_addr;
      lsu_region_t     region;
      logic            misaligned;
      logic            access_fault;
      logic [2:0]      mscause;
   } lsu_stage_t;

   // Payload of DC4 and DC5, addresses only
   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] end_addr;
   } lsu_addr_pair_t;

   // Exception report raised in DC3
   typedef struct packed {
      logic            exc_valid;
      logic            inst_type;  // 1 for a store
      logic            exc_type;   // 0 misaligned, 1 access fault
      logic            amo_valid;
      logic [2:0]      mscause;
      logic [XLEN-1:0] addr;
   } lsu_error_pkt_t;

endpackage

// File: reservation/lsu_reservation.sv
// DC5 commit, store-conditional check and the per-thread load reservations
module lsu_reservation (
   input  logic                            clk,
   input  logic                            reset,
   input  lsu_pkg::lsu_pkt_t               pkt_dc5,
   input  lsu_pkg::lsu_addr_pair_t         addr_dc5,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc5,
   input  logic [lsu_pkg::NUM_THREADS-1:0] lr_reset,
   output logic                            lsu_commit_dc5,
   output logic                            lsu_sc_success_dc5,
   output logic [lsu_pkg::NUM_THREADS-1:0] lr_vld
);

   localparam int THREADS = lsu_pkg::NUM_THREADS;

   logic [THREADS-1:0][31:2] lr_addr;     // Reserved word per thread
   logic [THREADS-1:0]       lr_set;
   logic [THREADS-1:0]       lr_clr;
   logic [THREADS-1:0]       sc_hit;

   assign lsu_commit_dc5 = pkt_dc5.valid & (pkt_dc5.load | pkt_dc5.store | pkt_dc5.atomic) &
                           ~flush_dc5[pkt_dc5.tid];

   // ********************
   // SC success
   // ********************

   always_comb begin
      sc_hit = '0;
      for (int i = 0; i < THREADS; i++) begin
         sc_hit[i] = (pkt_dc5.tid == i) & lr_vld[i] & (addr_dc5.addr[31:2] == lr_addr[i]);
      end
   end

   assign lsu_sc_success_dc5 = pkt_dc5.valid & pkt_dc5.sc & (|sc_hit);

   // ********************
   // Reservation stations
   // ********************

   for (genvar i = 0; i < THREADS; i++) begin : g_lr
      assign lr_set[i] = (pkt_dc5.tid == i) & lsu_commit_dc5 & pkt_dc5.lr;

      assign lr_clr[i] =
         ((pkt_dc5.tid == i) & lsu_commit_dc5 & pkt_dc5.sc) |  // Own SC, pass or fail
         ((pkt_dc5.tid != i) & lsu_commit_dc5 & pkt_dc5.store &
          (~pkt_dc5.sc | lsu_sc_success_dc5) &
          ((addr_dc5.addr[31:2] == lr_addr[i]) | (addr_dc5.end_addr[31:2] == lr_addr[i]))) |
         lr_reset[i];

      always_ff @(posedge clk) begin
         if (reset) begin
            lr_vld[i] <= 1'b0;
         end else if (lr_clr[i]) begin
            lr_vld[i] <= 1'b0;  // Clear beats set
         end else if (lr_set[i]) begin
            lr_vld[i] <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (lr_set[i]) begin
            lr_addr[i] <= addr_dc5.addr[31:2];
         end
      end
   end

endmodule

// File: verification/lsu_ctl_checker.sv
// Concurrent assertions on the LSU control top level, attached to lsu_ctl_top with bind
module lsu_ctl_checker (
   input logic                            clk,
   input logic                            reset,
   input lsu_pkg::lsu_pkt_t               pkt_dc5,
   input lsu_pkg::lsu_pkt_t               lsu_pkt_dc1,
   input lsu_pkg::lsu_pkt_t               lsu_pkt_dc3,
   input logic [lsu_pkg::NUM_THREADS-1:0] flush_dc3,
   input lsu_pkg::lsu_error_pkt_t         lsu_error_pkt_dc3,
   input logic                            lsu_commit_dc5,
   input logic                            lsu_sc_success_dc5,
   input logic [lsu_pkg::NUM_THREADS-1:0] lr_vld
);
   timeunit 1ns;
   timeprecision 1ps;

   logic reset_seen = 1'b0;  // Reset has been sampled by at least one edge

   always @(posedge clk) begin
      reset_seen <= reset;
   end

   // ********************
   // Pipeline rules
   // ********************

   commit_valid_a : assert property (@(posedge clk) lsu_commit_dc5 |-> pkt_dc5.valid)
      else $error("Commit without a valid DC5 op");

   sc_pkt_a : assert property (@(posedge clk) lsu_sc_success_dc5 |-> pkt_dc5.sc)
      else $error("SC success on an op that is not an sc");

   flush_exc_a : assert property (@(posedge clk)
      flush_dc3[lsu_pkt_dc3.tid] |-> !lsu_error_pkt_dc3.exc_valid)
      else $error("Exception raised by a DC3 op that is being flushed");

   reset_quiet_a : assert property (@(posedge clk) (reset && reset_seen) |->
      (!lsu_pkt_dc1.valid && !lsu_pkt_dc3.valid && !lsu_error_pkt_dc3.exc_valid &&
       !lsu_commit_dc5 && !lsu_sc_success_dc5 && (lr_vld == '0)))
      else $error("Valid output active during reset");

endmodule

// File: verification/lsu_ctl_tb.sv
// Table-driven testbench for the LSU control pipeline, runs one op at a time through DC1 to DC5
module lsu_ctl_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int NT           = lsu_pkg::NUM_THREADS;

   localparam logic [1:0] LD = 2'd0, ST = 2'd1, LR = 2'd2, SC = 2'd3;  // Op kinds
   localparam logic [1:0] B = 2'd0, H = 2'd1, W = 2'd2;                // Access sizes

   typedef struct packed {
      logic [1:0]  kind;
      logic [1:0]  size;
      logic        uns;
      logic        tid;
      logic [31:0] rs1;
      logic [11:0] off;
      logic [2:0]  flush;  // Stage to flush, 0 for none
      logic [1:0]  lrr;    // lr_reset pulse while the op is in DC1
      logic [1:0]  src;    // Expected data, 0 zero, 1 DCCM, 2 PIC, 3 bus
      logic [1:0]  exc;    // {exc_valid, exc_type}
      logic [2:0]  cause;
      logic [1:0]  cs;     // {commit, sc success}
      logic [1:0]  lr;     // lr_vld after the op
   } entry_t;

   logic                    clk = 1'b0;
   logic                    reset;
   lsu_pkg::lsu_pkt_t       lsu_p;
   logic [31:0]             rs1;
   logic [11:0]             offset;
   logic [NT-1:0]           flush_dc2_up, flush_dc3, flush_dc4, flush_dc5, lr_reset;
   logic [31:0]             dccm_rd_data, pic_rd_data, bus_rd_data;
   logic [31:0]             lsu_addr_dc1, lsu_result_dc3;
   lsu_pkg::lsu_pkt_t       lsu_pkt_dc1, lsu_pkt_dc3;
   lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3;
   logic                    lsu_commit_dc5, lsu_sc_success_dc5;
   logic [NT-1:0]           lr_vld;

   entry_t      tbl[$];
   string       names[$];
   logic [15:0] lfsr = 16'd55593;
   logic        table_ready = 1'b0;
   int          errors = 0;
   int          failed = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   lsu_ctl_top #(
      .DCCM_BASE(32'hF004_0000), .DCCM_SIZE(32'h0001_0000),
      .PIC_BASE(32'hF00C_0000), .PIC_SIZE(32'h0000_8000)
   ) dut_i (
      .clk, .reset, .lsu_p, .rs1, .offset, .flush_dc2_up, .flush_dc3, .flush_dc4, .flush_dc5,
      .lr_reset, .dccm_rd_data, .pic_rd_data, .bus_rd_data, .lsu_addr_dc1, .lsu_pkt_dc1,
      .lsu_pkt_dc3, .lsu_result_dc3, .lsu_error_pkt_dc3, .lsu_commit_dc5, .lsu_sc_success_dc5,
      .lr_vld
   );

   bind lsu_ctl_top lsu_ctl_checker checker_i (
      .clk, .reset, .pkt_dc5(lsu_pkt_dc5), .lsu_pkt_dc1, .lsu_pkt_dc3, .flush_dc3,
      .lsu_error_pkt_dc3, .lsu_commit_dc5, .lsu_sc_success_dc5, .lr_vld
   );

   // ********************
   // Helpers
   // ********************

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic random_word(output logic [31:0] w);
      for (int b = 0; b < 32; b++) begin
         w[b] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Low bytes differ so a wrong region shows in every size
   task automatic draw_read_data();
      do begin
         random_word(dccm_rd_data);
         random_word(pic_rd_data);
         random_word(bus_rd_data);
      end while (dccm_rd_data[7:0] == pic_rd_data[7:0] || dccm_rd_data[7:0] == bus_rd_data[7:0] ||
                 pic_rd_data[7:0] == bus_rd_data[7:0]);
   endtask

   function automatic lsu_pkg::lsu_pkt_t make_pkt(input entry_t e);
      lsu_pkg::lsu_pkt_t p;
      p        = '0;
      p.valid  = 1'b1;
      p.tid    = e.tid;
      p.load   = (e.kind == LD) || (e.kind == LR);
      p.store  = (e.kind == ST) || (e.kind == SC);
      p.lr     = e.kind == LR;
      p.sc     = e.kind == SC;
      p.atomic = p.lr | p.sc;
      p.by     = e.size == B;
      p.half   = e.size == H;
      p.word   = e.size == W;
      p.unsign = e.uns;
      return p;
   endfunction

   function automatic logic [31:0] expected_result(input entry_t e);
      logic [31:0] d;
      case (e.src)
         2'd1:    d = dccm_rd_data;
         2'd2:    d = pic_rd_data;
         2'd3:    d = bus_rd_data;
         default: return 32'h0;
      endcase
      case (e.size)
         B:       return e.uns ? {24'h0, d[7:0]} : {{24{d[7]}}, d[7:0]};
         H:       return e.uns ? {16'h0, d[15:0]} : {{16{d[15]}}, d[15:0]};
         default: return d;
      endcase
   endfunction

   task automatic add_entry(input string d, input logic [1:0] kind, size, input logic uns, tid,
                            input logic [31:0] rs1v, input logic [11:0] off,
                            input logic [2:0] fl, input logic [1:0] lrr, src, exc,
                            input logic [2:0] cause, input logic [1:0] cs, lr);
      names.push_back(d);
      tbl.push_back('{kind, size, uns, tid, rs1v, off, fl, lrr, src, exc, cause, cs, lr});
   endtask

   // ********************
   // Stimulus table
   // ********************

   task automatic fill_table();
      // name, kind, size, uns, tid, rs1, offset, flush, lr_reset, src, exc, cause, cs, lr_vld
      add_entry("ld b dccm s", LD, B, 0, 0, 32'hF004_0100, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 0);
      add_entry("ld b ext u", LD, B, 1, 0, 32'h0000_2001, 12'h000, 0, 0, 3, 2'b00, 0, 2'b10, 0);
      add_entry("ld h dccm s", LD, H, 0, 0, 32'hF004_0202, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 0);
      add_entry("ld h ext u", LD, H, 1, 1, 32'h0000_2000, 12'h002, 0, 0, 3, 2'b00, 0, 2'b10, 0);
      add_entry("ld w dccm", LD, W, 0, 1, 32'hF004_0204, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 0);
      add_entry("ld w pic", LD, W, 0, 0, 32'hF00C_0010, 12'h000, 0, 0, 2, 2'b00, 0, 2'b10, 0);
      add_entry("ld w ext", LD, W, 0, 0, 32'h8000_0000, 12'h000, 0, 0, 3, 2'b00, 0, 2'b10, 0);
      add_entry("st w dccm", ST, W, 0, 0, 32'hF004_0300, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 0);
      add_entry("neg dccm", LD, W, 0, 0, 32'hF004_0010, 12'hFF0, 0, 0, 1, 2'b00, 0, 2'b10, 0);
      add_entry("neg ext", LD, B, 0, 0, 32'hF004_0004, 12'hFF8, 0, 0, 3, 2'b00, 0, 2'b10, 0);
      add_entry("neg pic b", LD, B, 0, 0, 32'hF00C_0100, 12'hF00, 0, 0, 2, 2'b11, 2, 2'b10, 0);
      add_entry("mis pic w", LD, W, 0, 0, 32'hF00C_0002, 12'h000, 0, 0, 2, 2'b10, 0, 2'b10, 0);
      add_entry("mis ext h", LD, H, 0, 0, 32'h0000_3001, 12'h000, 0, 0, 3, 2'b10, 0, 2'b10, 0);
      add_entry("mis ext st", ST, W, 0, 1, 32'h0000_3002, 12'h000, 0, 0, 0, 2'b10, 0, 2'b10, 0);
      add_entry("cross dccm", LD, W, 0, 0, 32'hF004_FFFE, 12'h000, 0, 0, 1, 2'b11, 1, 2'b10, 0);
      add_entry("pic byte", LD, B, 1, 0, 32'hF00C_0004, 12'h000, 0, 0, 2, 2'b11, 2, 2'b10, 0);
      add_entry("mis dccm w", LD, W, 0, 0, 32'hF004_0003, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 0);
      add_entry("flush dc1", LD, W, 0, 0, 32'h0000_3002, 12'h000, 1, 0, 0, 2'b00, 0, 2'b00, 0);
      add_entry("flush dc3", LD, W, 0, 1, 32'h0000_3002, 12'h000, 3, 0, 3, 2'b00, 0, 2'b00, 0);
      add_entry("flush dc4", LD, B, 1, 1, 32'h0000_2003, 12'h000, 4, 0, 3, 2'b00, 0, 2'b00, 0);
      add_entry("flush dc5", LD, H, 0, 0, 32'h0000_3001, 12'h000, 5, 0, 3, 2'b10, 0, 2'b00, 0);
      add_entry("lr t0", LR, W, 0, 0, 32'hF004_0400, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 1);
      add_entry("sc t0 hit", SC, W, 0, 0, 32'hF004_0400, 12'h000, 0, 0, 0, 2'b00, 0, 2'b11, 0);
      add_entry("lr t0 again", LR, W, 0, 0, 32'hF004_0400, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 1);
      add_entry("sc t0 miss", SC, W, 0, 0, 32'hF004_0404, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 0);
      add_entry("lr t0 500", LR, W, 0, 0, 32'hF004_0500, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 1);
      add_entry("st t1 500", ST, W, 0, 1, 32'hF004_0500, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 0);
      add_entry("sc t0 500", SC, W, 0, 0, 32'hF004_0500, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 0);
      add_entry("lr t0 600", LR, W, 0, 0, 32'hF004_0600, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 1);
      add_entry("lr_reset t0", LD, W, 0, 1, 32'hF004_0700, 12'h000, 0, 1, 1, 2'b00, 0, 2'b10, 0);
      add_entry("sc t0 600", SC, W, 0, 0, 32'hF004_0600, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 0);
      add_entry("lr t1 700", LR, W, 0, 1, 32'hF004_0700, 12'h000, 0, 0, 1, 2'b00, 0, 2'b10, 2);
      add_entry("st t0 800", ST, W, 0, 0, 32'hF004_0800, 12'h000, 0, 0, 0, 2'b00, 0, 2'b10, 2);
      add_entry("sc t1 700", SC, W, 0, 1, 32'hF004_0700, 12'h000, 0, 0, 0, 2'b00, 0, 2'b11, 0);
   endtask

   // ********************
   // One op, D through DC5 plus the reservation update
   // ********************

   task automatic run_entry(input int i);
      entry_t            e;
      lsu_pkg::lsu_pkt_t exp_pkt;
      logic [31:0]       addr;
      logic [31:0]       exp_res;
      logic [NT-1:0]     tbit;
      int                off_val;
      int                errs_before;
      e           = tbl[i];
      errs_before = errors;
      off_val     = $signed(e.off);  // Offset as a signed number
      addr        = e.rs1 + off_val;
      tbit        = 1 << e.tid;
      exp_pkt     = make_pkt(e);
      @(posedge clk);
      #1;
      lsu_p  = exp_pkt;
      rs1    = e.rs1;
      offset = e.off;
      draw_read_data();
      exp_res = expected_result(e);
      for (int c = 1; c <= 6; c++) begin
         @(posedge clk);
         #1;
         lsu_p        = '0;
         flush_dc2_up = (e.flush == 3'd1 && c == 1) ? tbit : '0;
         flush_dc3    = (e.flush == 3'd3 && c == 3) ? tbit : '0;
         flush_dc4    = (e.flush == 3'd4 && c == 4) ? tbit : '0;
         flush_dc5    = (e.flush == 3'd5 && c == 5) ? tbit : '0;
         lr_reset     = (c == 1) ? e.lrr : '0;
         #(CLK_PERIOD / 2 - 1);  // Mid-cycle, outputs settled
         if (c == 1) begin
            check_value("lsu_addr_dc1", lsu_addr_dc1, addr);
            check_value("lsu_pkt_dc1", lsu_pkt_dc1, exp_pkt);
         end else if (c == 3) begin
            exp_pkt.valid = e.flush != 3'd1;  // Killed on the way out of DC1
            check_value("lsu_pkt_dc3", lsu_pkt_dc3, exp_pkt);
            check_value("lsu_result_dc3", lsu_result_dc3, exp_res);
            check_value("exc_valid", lsu_error_pkt_dc3.exc_valid, e.exc[1]);
            check_value("amo_valid", lsu_error_pkt_dc3.amo_valid, 1'b0);  // No AMO in the table
            if (e.exc[1]) begin
               check_value("exc_type", lsu_error_pkt_dc3.exc_type, e.exc[0]);
               check_value("mscause", lsu_error_pkt_dc3.mscause, e.cause);
               check_value("inst_type", lsu_error_pkt_dc3.inst_type,
                           (e.kind == ST) || (e.kind == SC));
               check_value("error addr", lsu_error_pkt_dc3.addr, addr);
            end else begin
               check_value("error addr", lsu_error_pkt_dc3.addr, '0);
            end
         end else if (c == 5) begin
            check_value("lsu_commit_dc5", lsu_commit_dc5, e.cs[1]);
            check_value("lsu_sc_success_dc5", lsu_sc_success_dc5, e.cs[0]);
         end else if (c == 6) begin
            check_value("lr_vld", lr_vld, e.lr);
         end
      end
      if (errors != errs_before) begin
         failed++;
      end
      $display("test %0d %s: %s", i, names[i], (errors == errs_before) ? "passed" : "failed");
   endtask

   // ********************
   // Main sequence and watchdog
   // ********************

   initial begin
      reset        = 1'b1;
      lsu_p        = '0;
      rs1          = '0;
      offset       = '0;
      flush_dc2_up = '0;
      flush_dc3    = '0;
      flush_dc4    = '0;
      flush_dc5    = '0;
      lr_reset     = '0;
      dccm_rd_data = '0;
      pic_rd_data  = '0;
      bus_rd_data  = '0;
      fill_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < tbl.size(); i++) begin
         run_entry(i);
      end
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
               tbl.size(), tbl.size() - failed, failed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      #((tbl.size() * 8 + RESET_CYCLES) * CLK_PERIOD);
      $display("Timeout: the test table did not finish in the expected time");
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: verilog/lsu_addr_stage.sv
// DC1 stage: registers the D-stage op, builds start and end address, decodes region and faults
module lsu_addr_stage #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter logic [31:0] DCCM_SIZE = 32'h0001_0000,
   parameter logic [31:0] PIC_BASE  = 32'hF00C_0000,
   parameter logic [31:0] PIC_SIZE  = 32'h0000_8000
) (
   input  logic                            clk,
   input  logic                            reset,
   input  lsu_pkg::lsu_pkt_t               lsu_p,
   input  logic [lsu_pkg::XLEN-1:0]        rs1,
   input  logic [11:0]                     offset,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc2_up,
   output lsu_pkg::lsu_pkt_t               pkt_dc1,
   output lsu_pkg::lsu_stage_t             stage_dc1
);

   lsu_pkg::lsu_pkt_t          pkt_q;
   logic                       valid_q;
   logic [lsu_pkg::XLEN-1:0]   rs1_q;
   logic [11:0]                offset_q;
   logic [lsu_pkg::XLEN-1:0]   start_addr;
   logic [lsu_pkg::XLEN-1:0]   end_addr;
   lsu_pkg::lsu_region_t       start_region;
   lsu_pkg::lsu_region_t       end_region;
   logic                       aligned;

   // Base/size match, sizes are powers of two
   function automatic lsu_pkg::lsu_region_t region_of(input logic [31:0] a);
      lsu_pkg::lsu_region_t r;
      r.in_dccm  = (a & ~(DCCM_SIZE - 32'd1)) == DCCM_BASE;
      r.in_pic   = (a & ~(PIC_SIZE - 32'd1)) == PIC_BASE;
      r.external = ~r.in_dccm & ~r.in_pic;
      return r;
   endfunction

   // ********************
   // D to DC1 registers
   // ********************

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= lsu_p.valid & ~flush_dc2_up[lsu_p.tid];
      end
   end

   always_ff @(posedge clk) begin
      pkt_q    <= lsu_p;
      rs1_q    <= rs1;
      offset_q <= offset;
   end

   always_comb begin
      pkt_dc1       = pkt_q;
      pkt_dc1.valid = valid_q;  // Killed copy wins over the raw bit
   end

   // ********************
   // Address and faults
   // ********************

   assign start_addr = rs1_q + {{20{offset_q[11]}}, offset_q};
   assign end_addr   = start_addr + {30'b0, pkt_q.word, pkt_q.word | pkt_q.half};  // Size minus one

   assign start_region = region_of(start_addr);
   assign end_region   = region_of(end_addr);

   assign aligned = ~(pkt_q.half & start_addr[0]) & ~(pkt_q.word & (start_addr[1:0] != 2'b00));

   always_comb begin
      stage_dc1.addr         = start_addr;
      stage_dc1.end_addr     = end_addr;
      stage_dc1.region       = start_region;
      stage_dc1.misaligned   = ~aligned & ~start_region.in_dccm;  // DCCM handles unaligned itself
      stage_dc1.access_fault = 1'b1;
      if (start_region != end_region) begin
         // A dual access that leaves its region
         stage_dc1.mscause = lsu_pkg::MSCAUSE_REGION_CROSS;
      end else if (start_region.in_pic & ~pkt_q.word) begin
         stage_dc1.mscause = lsu_pkg::MSCAUSE_PIC_SIZE;
      end else if (start_region.external & (pkt_q.lr | pkt_q.sc)) begin
         stage_dc1.mscause = lsu_pkg::MSCAUSE_UNMAPPED;
      end else begin
         stage_dc1.mscause      = lsu_pkg::MSCAUSE_NONE;
         stage_dc1.access_fault = 1'b0;
      end
   end

endmodule

// File: verilog/lsu_ctl_top.sv
// LSU control top level chaining the DC1 to DC5 stages of a core load or store
module lsu_ctl_top #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter logic [31:0] DCCM_SIZE = 32'h0001_0000,
   parameter logic [31:0] PIC_BASE  = 32'hF00C_0000,
   parameter logic [31:0] PIC_SIZE  = 32'h0000_8000
) (
   input  logic                            clk,
   input  logic                            reset,
   input  lsu_pkg::lsu_pkt_t               lsu_p,
   input  logic [lsu_pkg::XLEN-1:0]        rs1,
   input  logic [11:0]                     offset,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc2_up,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc3,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc4,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc5,
   input  logic [lsu_pkg::NUM_THREADS-1:0] lr_reset,
   input  logic [lsu_pkg::XLEN-1:0]        dccm_rd_data,
   input  logic [lsu_pkg::XLEN-1:0]        pic_rd_data,
   input  logic [lsu_pkg::XLEN-1:0]        bus_rd_data,
   output logic [lsu_pkg::XLEN-1:0]        lsu_addr_dc1,
   output lsu_pkg::lsu_pkt_t               lsu_pkt_dc1,
   output lsu_pkg::lsu_pkt_t               lsu_pkt_dc3,
   output logic [lsu_pkg::XLEN-1:0]        lsu_result_dc3,
   output lsu_pkg::lsu_error_pkt_t         lsu_error_pkt_dc3,
   output logic                            lsu_commit_dc5,
   output logic                            lsu_sc_success_dc5,
   output logic [lsu_pkg::NUM_THREADS-1:0] lr_vld
);

   lsu_pkg::lsu_pkt_t       lsu_pkt_dc2, lsu_pkt_dc4, lsu_pkt_dc5;
   lsu_pkg::lsu_stage_t     stage_dc1, stage_dc2, stage_dc3;
   lsu_pkg::lsu_addr_pair_t addr_dc3, addr_dc4, addr_dc5;

   // ********************
   // DC1
   // ********************

   lsu_addr_stage #(
      .DCCM_BASE(DCCM_BASE), .DCCM_SIZE(DCCM_SIZE), .PIC_BASE(PIC_BASE), .PIC_SIZE(PIC_SIZE)
   ) addr_stage_i (
      .clk, .reset, .lsu_p, .rs1, .offset, .flush_dc2_up,
      .pkt_dc1(lsu_pkt_dc1), .stage_dc1(stage_dc1)
   );

   assign lsu_addr_dc1 = stage_dc1.addr;

   // ********************
   // DC2 to DC5
   // ********************

   lsu_pipe_reg #(.payload_t(lsu_pkg::lsu_stage_t)) dc2_reg_i (
      .clk, .reset, .flush(flush_dc2_up), .pkt_in(lsu_pkt_dc1), .payload_in(stage_dc1),
      .pkt_out(lsu_pkt_dc2), .payload_out(stage_dc2)
   );

   lsu_pipe_reg #(.payload_t(lsu_pkg::lsu_stage_t)) dc3_reg_i (
      .clk, .reset, .flush(flush_dc2_up), .pkt_in(lsu_pkt_dc2), .payload_in(stage_dc2),
      .pkt_out(lsu_pkt_dc3), .payload_out(stage_dc3)
   );

   assign addr_dc3 = '{addr: stage_dc3.addr, end_addr: stage_dc3.end_addr};  // Region and faults end here

   lsu_pipe_reg #(.payload_t(lsu_pkg::lsu_addr_pair_t)) dc4_reg_i (
      .clk, .reset, .flush(flush_dc3), .pkt_in(lsu_pkt_dc3), .payload_in(addr_dc3),
      .pkt_out(lsu_pkt_dc4), .payload_out(addr_dc4)
   );

   lsu_pipe_reg #(.payload_t(lsu_pkg::lsu_addr_pair_t)) dc5_reg_i (
      .clk, .reset, .flush(flush_dc4), .pkt_in(lsu_pkt_dc4), .payload_in(addr_dc4),
      .pkt_out(lsu_pkt_dc5), .payload_out(addr_dc5)
   );

   lsu_load_format load_format_i (
      .pkt_dc3(lsu_pkt_dc3), .stage_dc3(stage_dc3), .flush_dc3,
      .dccm_rd_data, .pic_rd_data, .bus_rd_data, .lsu_result_dc3, .lsu_error_pkt_dc3
   );

   lsu_reservation reservation_i (
      .clk, .reset, .pkt_dc5(lsu_pkt_dc5), .addr_dc5(addr_dc5), .flush_dc5, .lr_reset,
      .lsu_commit_dc5, .lsu_sc_success_dc5, .lr_vld
   );

endmodule

// File: verilog/lsu_load_format.sv
// DC3 load data select and extension, plus the exception report for the DC3 op
module lsu_load_format (
   input  lsu_pkg::lsu_pkt_t               pkt_dc3,
   input  lsu_pkg::lsu_stage_t             stage_dc3,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush_dc3,
   input  logic [lsu_pkg::XLEN-1:0]        dccm_rd_data,
   input  logic [lsu_pkg::XLEN-1:0]        pic_rd_data,
   input  logic [lsu_pkg::XLEN-1:0]        bus_rd_data,
   output logic [lsu_pkg::XLEN-1:0]        lsu_result_dc3,
   output lsu_pkg::lsu_error_pkt_t         lsu_error_pkt_dc3
);

   logic [lsu_pkg::XLEN-1:0] ld_data;
   logic                     ld_vld;
   logic                     fault;

   // ********************
   // Read data
   // ********************

   // Region is one-hot, so an AND-OR mux
   assign ld_data = ({32{stage_dc3.region.in_dccm}}  & dccm_rd_data) |
                    ({32{stage_dc3.region.in_pic}}   & pic_rd_data)  |
                    ({32{stage_dc3.region.external}} & bus_rd_data);

   assign ld_vld = pkt_dc3.valid & pkt_dc3.load;

   always_comb begin
      lsu_result_dc3 = '0;  // Stores and idle slots read as zero
      if (ld_vld) begin
         if (pkt_dc3.by) begin
            lsu_result_dc3 = {{24{~pkt_dc3.unsign & ld_data[7]}}, ld_data[7:0]};
         end else if (pkt_dc3.half) begin
            lsu_result_dc3 = {{16{~pkt_dc3.unsign & ld_data[15]}}, ld_data[15:0]};
         end else if (pkt_dc3.word) begin
            lsu_result_dc3 = ld_data;
         end
      end
   end

   // ********************
   // Error packet
   // ********************

   assign fault = stage_dc3.access_fault | stage_dc3.misaligned;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = fault & pkt_dc3.valid & ~flush_dc3[pkt_dc3.tid];
      lsu_error_pkt_dc3.inst_type = pkt_dc3.store;
      // Misaligned takes precedence when both are present
      lsu_error_pkt_dc3.exc_type  = ~stage_dc3.misaligned;
      lsu_error_pkt_dc3.amo_valid = pkt_dc3.atomic & ~(pkt_dc3.lr | pkt_dc3.sc);
      lsu_error_pkt_dc3.mscause   = stage_dc3.mscause;
      lsu_error_pkt_dc3.addr      = stage_dc3.addr & {32{lsu_error_pkt_dc3.exc_valid}};
   end

endmodule

// File: verilog/lsu_pipe_reg.sv
// Stage register carrying the access packet and a payload one stage down, killed by flush
module lsu_pipe_reg #(
   parameter type payload_t = lsu_pkg::lsu_stage_t
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [lsu_pkg::NUM_THREADS-1:0] flush,
   input  lsu_pkg::lsu_pkt_t               pkt_in,
   input  payload_t                        payload_in,
   output lsu_pkg::lsu_pkt_t               pkt_out,
   output payload_t                        payload_out
);

   lsu_pkg::lsu_pkt_t pkt_q;
   logic              valid_q;

   // Valid with reset, flush of the leaving thread drops it
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= pkt_in.valid & ~flush[pkt_in.tid];
      end
   end

   // ********************
   // Packet body and payload
   // ********************

   always_ff @(posedge clk) begin
      pkt_q       <= pkt_in;
      payload_out <= payload_in;
   end

   always_comb begin
      pkt_out       = pkt_q;
      pkt_out.valid = valid_q;
   end

endmodule

// File: vlog.f
common/lsu_pkg.sv
verilog/lsu_addr_stage.sv
verilog/lsu_pipe_reg.sv
verilog/lsu_load_format.sv
reservation/lsu_reservation.sv
verilog/lsu_ctl_top.sv
verification/lsu_ctl_checker.sv
verification/lsu_ctl_tb.sv
